// ==== hdl/fifo_geom_pkg.sv ====
////////////////////////////////////////
// geometry of the dual-clock FIFO
// word width, entry count and the pointer types built from them
// import into any block that stores or indexes FIFO words
////////////////////////////////////////

package fifo_geom_pkg;

	// width of one stored word
	localparam int DATA_WIDTH = 32;

	// number of entries, must stay a power of two
	// so the pointer wrap flag lines up with the index
	localparam int DEPTH = 8;

	// entry index width
	localparam int ADDR_WIDTH = $clog2(DEPTH);

	typedef logic [DATA_WIDTH-1:0] data_t;
	typedef logic [ADDR_WIDTH-1:0] addr_t;

	// binary pointer, top bit is the wrap flag
	typedef logic [ADDR_WIDTH:0] ptr_t;

	// one write request into the storage array
	typedef struct packed {
		logic en;
		addr_t addr;
		data_t data;
	} mem_wr_t;

endpackage

// ==== hdl/cdc_pkg.sv ====
////////////////////////////////////////
// clock domain crossing helpers
// Gray pointer type, binary to Gray conversion
// and the default synchronizer depth
////////////////////////////////////////

package cdc_pkg;

	import fifo_geom_pkg::*;

	// Gray coded copy of a FIFO pointer
	// same width as the binary pointer, wrap flag included
	typedef logic [ADDR_WIDTH:0] gray_ptr_t;

	// flip-flops per crossing when the top level does not say otherwise
	localparam int DEFAULT_SYNC_STAGES = 2;

	////////////////////////////////////////
	// conversion
	////////////////////////////////////////

	// neighbouring binary values map to codes one bit apart
	// so a pointer can cross without tearing
	function automatic gray_ptr_t to_gray(input ptr_t bin);
		return bin ^ (bin >> 1);
	endfunction

endpackage

// ==== hdl/cdc_sync.sv ====
////////////////////////////////////////
// multi-flop synchronizer
// brings a word into the clock domain of clk
// used for Gray pointers and for the read-side reset
////////////////////////////////////////

module cdc_sync
	import cdc_pkg::*;
#(
	parameter int WIDTH = 1,
	parameter logic [WIDTH-1:0] RESET_VALUE = '0,
	parameter int STAGES = DEFAULT_SYNC_STAGES
)
(
	input logic clk,
	input logic reset,
	input logic [WIDTH-1:0] data_in,
	output logic [WIDTH-1:0] data_out
);

	// stage 0 samples the foreign domain
	// the last stage is the settled copy
	logic [STAGES-1:0][WIDTH-1:0] sync_q;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			// every stage holds the reset value
			sync_q <= {STAGES{RESET_VALUE}};
		end
		else
		begin
			// shift one stage per destination edge
			sync_q <= {sync_q[STAGES-2:0], data_in};
		end
	end

	assign data_out = sync_q[STAGES-1];

	// a single flop gives no time for metastability to resolve
	a_min_stages: assert property (@(posedge clk) STAGES >= 2);

endmodule

// ==== hdl/write_ptr_ctrl.sv ====
////////////////////////////////////////
// write side of the dual-clock FIFO
// keeps the write pointers, decodes full
// and turns accepted writes into memory requests
////////////////////////////////////////

module write_ptr_ctrl
	import fifo_geom_pkg::*, cdc_pkg::*;
(
	input logic write_clk,
	input logic reset_rsync,
	input logic write_en,
	input data_t write_data,
	input gray_ptr_t rptr_gray_sync,
	output logic full,
	output mem_wr_t mem_wr,
	output gray_ptr_t wptr_gray
);

	ptr_t wptr_bin;
	ptr_t wptr_bin_next;
	logic write_accept;

	////////////////////////////////////////
	// full decode
	////////////////////////////////////////

	// in Gray code a pointer one lap ahead differs in the top two bits
	// and matches in all the bits below them
	assign full = (wptr_gray[ADDR_WIDTH:ADDR_WIDTH-1] ==
			~rptr_gray_sync[ADDR_WIDTH:ADDR_WIDTH-1]) &&
		(wptr_gray[ADDR_WIDTH-2:0] == rptr_gray_sync[ADDR_WIDTH-2:0]);

	// writes while full are dropped
	assign write_accept = write_en && !full;
	assign wptr_bin_next = wptr_bin + 1'b1;

	// request goes out in the same cycle as the accept
	always_comb
	begin
		mem_wr.en = write_accept;
		mem_wr.addr = wptr_bin[ADDR_WIDTH-1:0];
		mem_wr.data = write_data;
	end

	////////////////////////////////////////
	// pointer registers
	////////////////////////////////////////

	always_ff @(posedge write_clk)
	begin
		if (reset_rsync)
		begin
			wptr_bin <= '0;
			wptr_gray <= '0;
		end
		else if (write_accept)
		begin
			// both copies move together
			wptr_bin <= wptr_bin_next;
			wptr_gray <= to_gray(wptr_bin_next);
		end
	end

	// no overwrite of unread entries
	a_no_advance_full: assert property (@(posedge write_clk) disable iff (reset_rsync)
		full |=> $stable(wptr_bin));

	// the read-side synchronizer must only ever see single-bit steps
	a_gray_one_bit: assert property (@(posedge write_clk) disable iff (reset_rsync)
		$countones(wptr_gray ^ $past(wptr_gray)) <= 1);

endmodule

// ==== hdl/read_ptr_ctrl.sv ====
////////////////////////////////////////
// read side of the dual-clock FIFO
// keeps the read pointers, decodes empty
// and points the read register at the head entry
////////////////////////////////////////

module read_ptr_ctrl
	import fifo_geom_pkg::*, cdc_pkg::*;
(
	input logic read_clk,
	input logic reset,
	input logic read_en,
	input gray_ptr_t wptr_gray_sync,
	output logic empty,
	output addr_t rd_addr,
	output logic rd_load,
	output gray_ptr_t rptr_gray
);

	ptr_t rptr_bin;
	ptr_t rptr_bin_next;
	logic pop;

	////////////////////////////////////////
	// empty decode
	////////////////////////////////////////

	// equal Gray pointers, wrap flag included, means nothing left
	// the synchronized copy lags, so empty may linger but never lies
	assign empty = (wptr_gray_sync == rptr_gray);

	// reads while empty are dropped
	assign pop = read_en && !empty;
	assign rptr_bin_next = rptr_bin + 1'b1;

	// head entry is reloaded on every edge with data present
	// a pop at that edge captures the popped word
	assign rd_load = !empty;
	assign rd_addr = rptr_bin[ADDR_WIDTH-1:0];

	////////////////////////////////////////
	// pointer registers
	////////////////////////////////////////

	always_ff @(posedge read_clk)
	begin
		if (reset)
		begin
			rptr_bin <= '0;
			rptr_gray <= '0;
		end
		else if (pop)
		begin
			rptr_bin <= rptr_bin_next;
			rptr_gray <= to_gray(rptr_bin_next);
		end
	end

	// reader can never run past the writer
	a_no_advance_empty: assert property (@(posedge read_clk) disable iff (reset)
		empty |=> $stable(rptr_bin));

endmodule

// ==== hdl/fifo_mem.sv ====
////////////////////////////////////////
// storage array of the dual-clock FIFO
// written on write_clk from a write request
// read into a registered word on read_clk
////////////////////////////////////////

module fifo_mem
	import fifo_geom_pkg::*;
(
	input logic write_clk,
	input logic read_clk,
	input logic read_reset,
	input mem_wr_t mem_wr,
	input addr_t rd_addr,
	input logic rd_load,
	output data_t read_data
);

	data_t mem [DEPTH];

	////////////////////////////////////////
	// write port
	////////////////////////////////////////

	always_ff @(posedge write_clk)
	begin
		if (mem_wr.en)
		begin
			mem[mem_wr.addr] <= mem_wr.data;
		end
	end

	////////////////////////////////////////
	// read port
	////////////////////////////////////////

	// an entry is only addressed once its pointer has crossed over
	// so the word is stable when sampled here
	always_ff @(posedge read_clk)
	begin
		if (read_reset)
		begin
			read_data <= '0;
		end
		else if (rd_load)
		begin
			// holds the last word while empty
			read_data <= mem[rd_addr];
		end
	end

endmodule

// ==== hdl/async_fifo.sv ====
////////////////////////////////////////
// dual-clock FIFO top level
// write side on write_clk, read side on read_clk
// Gray pointers cross through synchronizers
// reset_rsync is synchronous to write_clk
////////////////////////////////////////

module async_fifo
	import fifo_geom_pkg::*, cdc_pkg::*;
#(
	parameter int SYNC_STAGES = DEFAULT_SYNC_STAGES
)
(
	input logic write_clk,
	input logic read_clk,
	input logic reset_rsync,
	input logic write_en,
	input data_t write_data,
	output logic full,
	input logic read_en,
	output data_t read_data,
	output logic empty
);

	// reset as seen by the read domain
	logic rd_reset;

	mem_wr_t mem_wr;
	addr_t rd_addr;
	logic rd_load;

	// pointers and their copies in the opposite domain
	gray_ptr_t wptr_gray;
	gray_ptr_t wptr_gray_sync;
	gray_ptr_t rptr_gray;
	gray_ptr_t rptr_gray_sync;

	////////////////////////////////////////
	// read-domain reset
	////////////////////////////////////////

	// comes up asserted and releases SYNC_STAGES read edges after reset_rsync
	cdc_sync #(.WIDTH(1), .RESET_VALUE(1'b1), .STAGES(SYNC_STAGES)) rd_reset_sync (
		.clk(read_clk),
		.reset(reset_rsync),
		.data_in(1'b0),
		.data_out(rd_reset)
	);

	////////////////////////////////////////
	// write side and storage
	////////////////////////////////////////

	write_ptr_ctrl u_write_ptr_ctrl (
		.write_clk(write_clk),
		.reset_rsync(reset_rsync),
		.write_en(write_en),
		.write_data(write_data),
		.rptr_gray_sync(rptr_gray_sync),
		.full(full),
		.mem_wr(mem_wr),
		.wptr_gray(wptr_gray)
	);

	fifo_mem u_fifo_mem (
		.write_clk(write_clk),
		.read_clk(read_clk),
		.read_reset(rd_reset),
		.mem_wr(mem_wr),
		.rd_addr(rd_addr),
		.rd_load(rd_load),
		.read_data(read_data)
	);

	////////////////////////////////////////
	// pointer crossings
	////////////////////////////////////////

	// write pointer into the read domain
	cdc_sync #(.WIDTH($bits(gray_ptr_t)), .RESET_VALUE('0), .STAGES(SYNC_STAGES)) wptr_sync (
		.clk(read_clk),
		.reset(rd_reset),
		.data_in(wptr_gray),
		.data_out(wptr_gray_sync)
	);

	// read pointer into the write domain
	cdc_sync #(.WIDTH($bits(gray_ptr_t)), .RESET_VALUE('0), .STAGES(SYNC_STAGES)) rptr_sync (
		.clk(write_clk),
		.reset(reset_rsync),
		.data_in(rptr_gray),
		.data_out(rptr_gray_sync)
	);

	////////////////////////////////////////
	// read side
	////////////////////////////////////////

	read_ptr_ctrl u_read_ptr_ctrl (
		.read_clk(read_clk),
		.reset(rd_reset),
		.read_en(read_en),
		.wptr_gray_sync(wptr_gray_sync),
		.empty(empty),
		.rd_addr(rd_addr),
		.rd_load(rd_load),
		.rptr_gray(rptr_gray)
	);

endmodule

// ==== verif/tb_async_fifo.sv ====
////////////////////////////////////////
// testbench for the dual-clock FIFO
// write_clk period 4, read_clk period 6
// fixed words come from verif/fifo_input.txt
// random traffic from an LCG, checked against a queue
////////////////////////////////////////

module tb_async_fifo
	import fifo_geom_pkg::*;
();

	localparam int SYNC_STAGES = 2;
	localparam logic [31:0] SEED = 32'hd375f6a3;
	localparam int WAIT_LIMIT = 200;
	localparam int RANDOM_WRITES = 300;
	localparam int RANDOM_LIMIT = 5000;

	logic write_clk;
	logic read_clk;
	logic reset_rsync;
	logic write_en;
	data_t write_data;
	logic full;
	logic read_en;
	data_t read_data;
	logic empty;

	int error_count;
	int timeout_count;

	// words from the data file
	data_t fill_words[$];
	data_t order_words[$];

	// scoreboard for the random phase
	data_t expect_q[$];
	int random_accepted;
	logic random_writes_done;

	// separate streams so the two clock domains never share state
	logic [31:0] wr_state;
	logic [31:0] rd_state;

	async_fifo #(.SYNC_STAGES(SYNC_STAGES)) DUT (
		.write_clk(write_clk),
		.read_clk(read_clk),
		.reset_rsync(reset_rsync),
		.write_en(write_en),
		.write_data(write_data),
		.full(full),
		.read_en(read_en),
		.read_data(read_data),
		.empty(empty)
	);

	always #2 write_clk = ~write_clk;
	always #3 read_clk = ~read_clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic report_mismatch(input string test, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("error %s: expected %h, actual %h", test, expected, actual);
		error_count++;
	endtask

	////////////////////////////////////////
	// data file and handshake helpers
	////////////////////////////////////////

	task automatic load_words();
		int fd;
		int tag;
		logic [31:0] word;
		string line;
		fd = $fopen("verif/fifo_input.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the input data file verif/fifo_input.txt");
			error_count++;
			return;
		end
		while (!$feof(fd))
		begin
			line = "";
			void'($fgets(line, fd));
			// comment lines start with a hash
			if (line.len() > 0 && line[0] != "#")
			begin
				if ($sscanf(line, "%d %h", tag, word) == 2)
				begin
					if (tag == 1)
						fill_words.push_back(word);
					else if (tag == 2)
						order_words.push_back(word);
				end
			end
		end
		$fclose(fd);
	endtask

	// waits out full, then holds write_en for one write edge
	task automatic write_word(input data_t word);
		int waited;
		waited = 0;
		@(negedge write_clk);
		while (full && waited < WAIT_LIMIT)
		begin
			@(negedge write_clk);
			waited++;
		end
		if (full)
		begin
			$display("timeout: the write side stayed full");
			timeout_count++;
			return;
		end
		write_en = 1'b1;
		write_data = word;
		@(negedge write_clk);
		write_en = 1'b0;
	endtask

	task automatic wait_data_ready(input string test);
		int waited;
		waited = 0;
		@(negedge read_clk);
		while (empty && waited < WAIT_LIMIT)
		begin
			@(negedge read_clk);
			waited++;
		end
		if (empty)
		begin
			$display("timeout: empty never fell during test %s", test);
			timeout_count++;
		end
	endtask

	// popped word is on read_data by the next falling edge
	task automatic pop_word(input string test, output data_t got);
		wait_data_ready(test);
		if (timeout_count != 0)
			return;
		read_en = 1'b1;
		@(negedge read_clk);
		read_en = 1'b0;
		got = read_data;
	endtask

	////////////////////////////////////////
	// directed tests
	////////////////////////////////////////

	task automatic check_reset_state();
		if (empty !== 1'b1)
			report_mismatch("reset empty", 32'd1, 32'(empty));
		if (full !== 1'b0)
			report_mismatch("reset full", 32'd0, 32'(full));
		if (read_data !== '0)
			report_mismatch("reset read_data", 32'd0, read_data);
	endtask

	task automatic run_ordered();
		data_t got;
		foreach (order_words[i])
			write_word(order_words[i]);
		foreach (order_words[i])
		begin
			pop_word("ordered", got);
			if (timeout_count != 0)
				return;
			if (got !== order_words[i])
				report_mismatch("ordered", order_words[i], got);
		end
	endtask

	task automatic run_fill();
		data_t got;
		if (fill_words.size() != DEPTH)
		begin
			$display("the data file must hold exactly %0d fill words", DEPTH);
			error_count++;
			return;
		end
		foreach (fill_words[i])
			write_word(fill_words[i]);
		if (full !== 1'b1)
			report_mismatch("fill full", 32'd1, 32'(full));
		wait_data_ready("fill");
		if (timeout_count != 0)
			return;
		// a ninth write must bounce off full
		@(negedge write_clk);
		write_en = 1'b1;
		write_data = ~fill_words[0];
		@(negedge write_clk);
		write_en = 1'b0;
		if (full !== 1'b1)
			report_mismatch("overflow full", 32'd1, 32'(full));
		foreach (fill_words[i])
		begin
			pop_word("fill", got);
			if (timeout_count != 0)
				return;
			if (got !== fill_words[i])
				report_mismatch("fill", fill_words[i], got);
		end
		if (empty !== 1'b1)
			report_mismatch("fill drained empty", 32'd1, 32'(empty));
	endtask

	// read_en held high across an empty FIFO
	task automatic run_hold_on_empty();
		data_t held;
		data_t word;
		int waited;
		held = read_data;
		wr_state = lcg_next(wr_state);
		word = wr_state;
		@(negedge read_clk);
		read_en = 1'b1;
		repeat (6)
		begin
			@(negedge read_clk);
			if (read_data !== held)
				report_mismatch("hold on empty", held, read_data);
		end
		write_word(word);
		waited = 0;
		@(negedge read_clk);
		while (empty && waited < WAIT_LIMIT)
		begin
			if (read_data !== held)
				report_mismatch("hold on empty", held, read_data);
			@(negedge read_clk);
			waited++;
		end
		if (empty)
		begin
			$display("timeout: the word written after underflow never arrived");
			timeout_count++;
			read_en = 1'b0;
			return;
		end
		// pop happens at the edge in between
		@(negedge read_clk);
		read_en = 1'b0;
		if (read_data !== word)
			report_mismatch("next after empty", word, read_data);
	endtask

	////////////////////////////////////////
	// random traffic on both clocks
	////////////////////////////////////////

	task automatic random_writer();
		int waited;
		waited = 0;
		while (random_accepted < RANDOM_WRITES && waited < RANDOM_LIMIT)
		begin
			@(negedge write_clk);
			wr_state = lcg_next(wr_state);
			// enable about three cycles in four
			if (wr_state[31:30] != 2'b00)
			begin
				wr_state = lcg_next(wr_state);
				write_en = 1'b1;
				write_data = wr_state;
				if (!full)
				begin
					expect_q.push_back(wr_state);
					random_accepted++;
				end
			end
			else
				write_en = 1'b0;
			waited++;
		end
		@(negedge write_clk);
		write_en = 1'b0;
		if (random_accepted < RANDOM_WRITES)
		begin
			$display("timeout: the random writer got only %0d writes in", random_accepted);
			timeout_count++;
		end
		random_writes_done = 1'b1;
	endtask

	task automatic random_reader();
		int popped;
		int waited;
		logic pending;
		data_t expected;
		popped = 0;
		waited = 0;
		pending = 1'b0;
		while (waited < RANDOM_LIMIT &&
			!(random_writes_done && popped == random_accepted && !pending))
		begin
			@(negedge read_clk);
			if (pending)
			begin
				expected = expect_q.pop_front();
				if (read_data !== expected)
					report_mismatch("random", expected, read_data);
				popped++;
			end
			rd_state = lcg_next(rd_state);
			read_en = rd_state[31];
			// empty only changes on read_clk, so this decides the next edge
			pending = rd_state[31] && !empty;
			waited++;
		end
		read_en = 1'b0;
		if (!(random_writes_done && popped == random_accepted))
		begin
			$display("timeout: the random reader popped %0d of %0d words", popped,
				random_accepted);
			timeout_count++;
		end
	endtask

	task automatic run_random();
		fork
			random_writer();
			random_reader();
		join
		if (expect_q.size() != 0)
		begin
			$display("%0d accepted words were never read back", expect_q.size());
			error_count++;
		end
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial
	begin
		write_clk = 1'b0;
		read_clk = 1'b0;
		reset_rsync = 1'b1;
		write_en = 1'b0;
		write_data = '0;
		read_en = 1'b0;
		error_count = 0;
		timeout_count = 0;
		random_accepted = 0;
		random_writes_done = 1'b0;
		wr_state = SEED;
		rd_state = ~SEED;
		load_words();
		repeat (8) @(posedge write_clk);
		@(negedge write_clk);
		reset_rsync = 1'b0;
		// read-domain reset releases SYNC_STAGES read edges later
		repeat (SYNC_STAGES + 2) @(negedge read_clk);
		check_reset_state();
		if (timeout_count == 0)
			run_ordered();
		if (timeout_count == 0)
			run_fill();
		if (timeout_count == 0)
			run_hold_on_empty();
		if (timeout_count == 0)
			run_random();
		$display("errors: %0d mismatches, %0d timeouts", error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// ==== filelist.f ====
hdl/fifo_geom_pkg.sv
hdl/cdc_pkg.sv
hdl/cdc_sync.sv
hdl/write_ptr_ctrl.sv
hdl/read_ptr_ctrl.sv
hdl/fifo_mem.sv
hdl/async_fifo.sv
verif/tb_async_fifo.sv

// ==== Makefile ====
# Verilator build and run for the dual-clock FIFO testbench
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP ?= tb_async_fifo
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
FAIL_MSG ?= Finished with errors
PASS_MSG ?= Finished with no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	elif grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation ended without a result line, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/fifo_input.txt ====
# columns: tag, then one 32-bit word in hex
# tag 1 = fill words for the full test, tag 2 = ordered words read back in file order
2 00000001
2 12345678
2 deadbeef
2 cafef00d
2 80000000
2 7fffffff
2 0f0f0f0f
2 f0f0f0f0
1 a5a5a5a5
1 5a5a5a5a
1 ffffffff
1 00000000
1 13579bdf
1 2468ace0
1 c001d00d
1 0badf00d
